//--- include/tank_params.svh
`ifndef TANK_PARAMS_SVH
`define TANK_PARAMS_SVH

// grid geometry
`define TANK_GRID_BITS      5
`define TANK_GRID_MAX       31

// clock cycles per tick
`define TANK_MOVE_DIV       16
`define TANK_BUL_DIV        4

`define TANK_NUM_ENEMY      4

// enemy spawn cells, slot order 0..3
`define TANK_SPAWN_X0       4
`define TANK_SPAWN_Y0       4
`define TANK_SPAWN_X1       27
`define TANK_SPAWN_Y1       4
`define TANK_SPAWN_X2       4
`define TANK_SPAWN_Y2       27
`define TANK_SPAWN_X3       27
`define TANK_SPAWN_Y3       27

`define TANK_START_X        16
`define TANK_START_Y        16

`define TANK_RESPAWN_TICKS  8   // move ticks
`define TANK_SCORE_LIMIT    6
`define TANK_SCORE_BITS     5

`endif

//--- rtl/bullet_engine.sv
`timescale 1ns/1ns
`default_nettype none

module bullet_engine (
	input  wire                       clk,
	input  wire                       rst_n,
	input  wire                       running,
	input  wire                       bul_tick,
	input  wire                       fire_req,
	input  wire tank_geom_pkg::cell_t tank_cell,
	input  wire tank_geom_pkg::dir_t  tank_dir,
	input  wire                       hit,
	output logic                      bul_active,
	output tank_geom_pkg::cell_t      bul_cell
);

	tank_geom_pkg::dir_t bul_dir;	// heading latched at launch

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			bul_active <= 1'b0;
			bul_cell   <= '0;
		end else if (!running || hit) begin
			bul_active <= 1'b0;	// hit retires it, cell kept
		end else if (!bul_active) begin
			if (fire_req) begin
				bul_active <= 1'b1;
				bul_cell   <= tank_cell;
			end
		end else if (bul_tick) begin
			if (tank_geom_pkg::at_edge(bul_cell, bul_dir)) begin
				bul_active <= 1'b0;	// would leave the grid
			end else begin
				bul_cell <= tank_geom_pkg::step_cell(bul_cell, bul_dir);
			end
		end
	end

	// heading only matters while active
	always_ff @(posedge clk) begin
		if (fire_req && !bul_active) begin
			bul_dir <= tank_dir;
		end
	end

	a_idle_cell: assert property (@(posedge clk) disable iff (!rst_n)
		!bul_active ##1 !bul_active |-> $stable(bul_cell))
		else $error("bullet cell moved while inactive");

endmodule

`default_nettype wire

//--- rtl/enemy_field.sv
`timescale 1ns/1ns
`default_nettype none

`include "tank_params.svh"

module enemy_field (
	input  wire                        clk,
	input  wire                        rst_n,
	input  wire                        running,
	input  wire                        move_tick,
	input  wire                        bul_active,
	input  wire tank_geom_pkg::cell_t  bul_cell,
	output logic                       hit,
	output logic [`TANK_NUM_ENEMY-1:0] alive
);

	localparam int CNT_W = $clog2(`TANK_RESPAWN_TICKS + 1);

	// fixed spawn cells, one per slot
	localparam tank_geom_pkg::cell_t SPAWN [`TANK_NUM_ENEMY] = '{
		'{x: tank_geom_pkg::coord_t'(`TANK_SPAWN_X0), y: tank_geom_pkg::coord_t'(`TANK_SPAWN_Y0)},
		'{x: tank_geom_pkg::coord_t'(`TANK_SPAWN_X1), y: tank_geom_pkg::coord_t'(`TANK_SPAWN_Y1)},
		'{x: tank_geom_pkg::coord_t'(`TANK_SPAWN_X2), y: tank_geom_pkg::coord_t'(`TANK_SPAWN_Y2)},
		'{x: tank_geom_pkg::coord_t'(`TANK_SPAWN_X3), y: tank_geom_pkg::coord_t'(`TANK_SPAWN_Y3)}
	};

	logic [`TANK_NUM_ENEMY-1:0] hit_vec;
	logic [CNT_W-1:0]           wait_cnt [`TANK_NUM_ENEMY];	// move ticks since death

	always_comb begin
		for (int i = 0; i < `TANK_NUM_ENEMY; i++) begin
			hit_vec[i] = bul_active && alive[i] && (bul_cell == SPAWN[i]);
		end
	end

	assign hit = |hit_vec;

	always_ff @(posedge clk) begin
		if (!rst_n || !running) begin
			// field fully stocked outside play
			alive <= '1;
			for (int i = 0; i < `TANK_NUM_ENEMY; i++) begin
				wait_cnt[i] <= '0;
			end
		end else begin
			for (int i = 0; i < `TANK_NUM_ENEMY; i++) begin
				if (hit_vec[i]) begin
					alive[i]    <= 1'b0;
					wait_cnt[i] <= '0;
				end else if (!alive[i] && move_tick) begin
					if (wait_cnt[i] == CNT_W'(`TANK_RESPAWN_TICKS - 1)) begin
						alive[i] <= 1'b1;	// back on its spawn cell
					end else begin
						wait_cnt[i] <= wait_cnt[i] + 1'b1;
					end
				end
			end
		end
	end

	a_one_kill: assert property (@(posedge clk) disable iff (!rst_n)
		hit && running |=> $onehot($past(alive) & ~alive))
		else $error("hit did not remove exactly one enemy");

endmodule

`default_nettype wire

//--- rtl/game_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

`include "tank_params.svh"

module game_ctrl (
	input  wire                         clk,
	input  wire                         rst_n,
	input  wire                         start,
	input  wire                         hit,
	output tank_game_pkg::game_state_t  state,
	output logic                        running,
	output logic [`TANK_SCORE_BITS-1:0] score
);

	localparam logic [`TANK_SCORE_BITS-1:0] LAST_HIT = `TANK_SCORE_LIMIT - 1;

	assign running = (state == tank_game_pkg::ST_RUNNING);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= tank_game_pkg::ST_IDLE;
			score <= '0;
		end else begin
			case (state)
				tank_game_pkg::ST_IDLE,
				tank_game_pkg::ST_OVER: begin
					if (start) begin
						state <= tank_game_pkg::ST_RUNNING;
						score <= '0;	// fresh game
					end
				end
				tank_game_pkg::ST_RUNNING: begin
					if (hit) begin
						score <= score + 1'b1;
						if (score == LAST_HIT) begin
							state <= tank_game_pkg::ST_OVER;
						end
					end
				end
				default: state <= tank_game_pkg::ST_IDLE;
			endcase
		end
	end

	a_score_cap: assert property (@(posedge clk) disable iff (!rst_n)
		score <= `TANK_SCORE_BITS'(`TANK_SCORE_LIMIT))
		else $error("score above limit");

endmodule

`default_nettype wire

//--- rtl/player_tank.sv
`timescale 1ns/1ns
`default_nettype none

`include "tank_params.svh"

module player_tank (
	input  wire                  clk,
	input  wire                  rst_n,
	input  wire                  running,
	input  wire                  move_tick,
	input  wire                  cmd_valid,
	input  wire tank_game_pkg::cmd_t cmd,
	output logic                 cmd_ready,
	output tank_geom_pkg::cell_t tank_cell,
	output tank_geom_pkg::dir_t  tank_dir,
	output logic                 fire_req
);

	logic                 taken;	// command already accepted since last move tick
	logic                 xfer;
	tank_geom_pkg::cell_t next_cell;

	assign cmd_ready = running && !taken;
	assign xfer      = cmd_valid && cmd_ready;

	// clamp at the grid border
	always_comb begin
		next_cell = tank_cell;
		if (!tank_geom_pkg::at_edge(tank_cell, cmd.dir)) begin
			next_cell = tank_geom_pkg::step_cell(tank_cell, cmd.dir);
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			taken       <= 1'b0;
			fire_req    <= 1'b0;
			tank_cell.x <= tank_geom_pkg::coord_t'(`TANK_START_X);
			tank_cell.y <= tank_geom_pkg::coord_t'(`TANK_START_Y);
			tank_dir    <= tank_geom_pkg::DIR_UP;
		end else begin
			fire_req <= xfer && cmd.fire;	// single cycle pulse
			if (xfer) begin
				taken <= 1'b1;	// wins over a tick in the same cycle
			end else if (move_tick) begin
				taken <= 1'b0;
			end
			if (xfer && cmd.move) begin
				tank_cell <= next_cell;
				tank_dir  <= cmd.dir;	// turns even when clamped
			end
		end
	end

	function automatic logic near_cell(tank_geom_pkg::cell_t a, tank_geom_pkg::cell_t b);
		logic same_x;
		logic same_y;
		same_x = (a.x == b.x);
		same_y = (a.y == b.y);
		return (same_x && same_y) ||
			(same_x && (a.y - b.y == 1 || b.y - a.y == 1)) ||
			(same_y && (a.x - b.x == 1 || b.x - a.x == 1));
	endfunction

	a_one_step: assert property (@(posedge clk) disable iff (!rst_n)
		xfer |=> near_cell($past(tank_cell), tank_cell))
		else $error("tank moved more than one cell");

endmodule

`default_nettype wire

//--- rtl/tank_game_pkg.sv
`default_nettype none

`include "tank_params.svh"

package tank_game_pkg;

	// one command per accepted transfer
	typedef struct packed {
		logic                move;	// step one cell in dir
		tank_geom_pkg::dir_t dir;
		logic                fire;
	} cmd_t;

	typedef enum logic [1:0] {
		ST_IDLE    = 2'd0,
		ST_RUNNING = 2'd1,
		ST_OVER    = 2'd2
	} game_state_t;

	// snapshot of the playfield, 38 bits
	typedef struct packed {
		tank_geom_pkg::cell_t       player_cell;
		tank_geom_pkg::dir_t        player_dir;
		logic                       bul_active;
		tank_geom_pkg::cell_t       bul_cell;
		logic [`TANK_NUM_ENEMY-1:0] alive;
		logic [`TANK_SCORE_BITS-1:0] score;
		game_state_t                state;
		logic                       game_over;
		logic                       running;
		logic [1:0]                 spare;
	} status_t;

endpackage

`default_nettype wire

//--- rtl/tank_game_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "tank_params.svh"

module tank_game_top (
	input  wire                      clk,
	input  wire                      rst_n,
	input  wire                      start,
	input  wire                      cmd_valid,
	input  wire tank_game_pkg::cmd_t cmd,
	output logic                     cmd_ready,
	output tank_game_pkg::status_t   status
);

	logic                        move_tick;
	logic                        bul_tick;
	logic                        running;
	tank_game_pkg::game_state_t  state;
	logic [`TANK_SCORE_BITS-1:0] score;
	tank_geom_pkg::cell_t        tank_cell;
	tank_geom_pkg::dir_t         tank_dir;
	logic                        fire_req;
	logic                        bul_active;
	tank_geom_pkg::cell_t        bul_cell;
	logic                        hit;
	logic [`TANK_NUM_ENEMY-1:0]  alive;

	tick_gen u_tick_gen (
		.clk		(clk),
		.rst_n		(rst_n),
		.move_tick	(move_tick),
		.bul_tick	(bul_tick)
	);

	game_ctrl u_game_ctrl (
		.clk		(clk),
		.rst_n		(rst_n),
		.start		(start),
		.hit		(hit),
		.state		(state),
		.running	(running),
		.score		(score)
	);

	player_tank u_player_tank (
		.clk		(clk),
		.rst_n		(rst_n),
		.running	(running),
		.move_tick	(move_tick),
		.cmd_valid	(cmd_valid),
		.cmd		(cmd),
		.cmd_ready	(cmd_ready),
		.tank_cell	(tank_cell),
		.tank_dir	(tank_dir),
		.fire_req	(fire_req)
	);

	bullet_engine u_bullet_engine (
		.clk		(clk),
		.rst_n		(rst_n),
		.running	(running),
		.bul_tick	(bul_tick),
		.fire_req	(fire_req),
		.tank_cell	(tank_cell),
		.tank_dir	(tank_dir),
		.hit		(hit),
		.bul_active	(bul_active),
		.bul_cell	(bul_cell)
	);

	// hit detection lives here only
	enemy_field u_enemy_field (
		.clk		(clk),
		.rst_n		(rst_n),
		.running	(running),
		.move_tick	(move_tick),
		.bul_active	(bul_active),
		.bul_cell	(bul_cell),
		.hit		(hit),
		.alive		(alive)
	);

	assign status = '{
		player_cell: tank_cell,
		player_dir:  tank_dir,
		bul_active:  bul_active,
		bul_cell:    bul_cell,
		alive:       alive,
		score:       score,
		state:       state,
		game_over:   (state == tank_game_pkg::ST_OVER),
		running:     running,
		spare:       2'b00
	};

endmodule

`default_nettype wire

//--- rtl/tank_geom_pkg.sv
`default_nettype none

`include "tank_params.svh"

package tank_geom_pkg;

	typedef logic [`TANK_GRID_BITS-1:0] coord_t;

	typedef enum logic [1:0] {
		DIR_UP    = 2'd0,	// towards y = 0
		DIR_DOWN  = 2'd1,
		DIR_LEFT  = 2'd2,	// towards x = 0
		DIR_RIGHT = 2'd3
	} dir_t;

	typedef struct packed {
		coord_t x;
		coord_t y;
	} cell_t;

	// true when one more step in d would leave the grid
	function automatic logic at_edge(cell_t c, dir_t d);
		case (d)
			DIR_UP:    return c.y == '0;
			DIR_DOWN:  return c.y == coord_t'(`TANK_GRID_MAX);
			DIR_LEFT:  return c.x == '0;
			DIR_RIGHT: return c.x == coord_t'(`TANK_GRID_MAX);
		endcase
		return 1'b1;
	endfunction

	// one cell in d, no edge check
	function automatic cell_t step_cell(cell_t c, dir_t d);
		cell_t n;
		n = c;
		case (d)
			DIR_UP:    n.y = c.y - 1'b1;
			DIR_DOWN:  n.y = c.y + 1'b1;
			DIR_LEFT:  n.x = c.x - 1'b1;
			DIR_RIGHT: n.x = c.x + 1'b1;
		endcase
		return n;
	endfunction

endpackage

`default_nettype wire

//--- rtl/tick_gen.sv
`timescale 1ns/1ns
`default_nettype none

`include "tank_params.svh"

module tick_gen (
	input  wire  clk,
	input  wire  rst_n,
	output logic move_tick,
	output logic bul_tick
);

	localparam int MOVE_W = $clog2(`TANK_MOVE_DIV);
	localparam int BUL_W  = $clog2(`TANK_BUL_DIV);

	logic [MOVE_W-1:0] move_cnt;
	logic [BUL_W-1:0]  bul_cnt;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			move_cnt  <= '0;
			bul_cnt   <= '0;
			move_tick <= 1'b0;
			bul_tick  <= 1'b0;
		end else begin
			move_cnt  <= (move_cnt == MOVE_W'(`TANK_MOVE_DIV - 1)) ? '0 : move_cnt + 1'b1;
			bul_cnt   <= (bul_cnt == BUL_W'(`TANK_BUL_DIV - 1)) ? '0 : bul_cnt + 1'b1;
			move_tick <= (move_cnt == MOVE_W'(`TANK_MOVE_DIV - 1));	// once per wrap
			bul_tick  <= (bul_cnt == BUL_W'(`TANK_BUL_DIV - 1));
		end
	end

	a_move_pulse: assert property (@(posedge clk) disable iff (!rst_n) move_tick |=> !move_tick)
		else $error("move_tick high for two cycles");
	a_bul_pulse: assert property (@(posedge clk) disable iff (!rst_n) bul_tick |=> !bul_tick)
		else $error("bul_tick high for two cycles");

endmodule

`default_nettype wire

//--- test/tank_game_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "tank_params.svh"

module tank_game_tb;

	localparam int MOVE_DIV    = `TANK_MOVE_DIV;
	localparam int RESPAWN_CYC = (`TANK_RESPAWN_TICKS + 1) * `TANK_MOVE_DIV;
	localparam int TIMEOUT_CYC = 400 * `TANK_MOVE_DIV;
	localparam int ST_IDLE     = 0;
	localparam int ST_RUN      = 1;
	localparam int ST_OVER     = 2;

	localparam tank_geom_pkg::cell_t START_CELL = '{x: `TANK_START_X, y: `TANK_START_Y};
	localparam tank_geom_pkg::cell_t SPAWN [`TANK_NUM_ENEMY] = '{
		'{x: `TANK_SPAWN_X0, y: `TANK_SPAWN_Y0}, '{x: `TANK_SPAWN_X1, y: `TANK_SPAWN_Y1},
		'{x: `TANK_SPAWN_X2, y: `TANK_SPAWN_Y2}, '{x: `TANK_SPAWN_X3, y: `TANK_SPAWN_Y3}
	};

	logic                   clk;
	logic                   rst_n;
	logic                   start;
	logic                   cmd_valid;
	logic                   cmd_ready;
	tank_game_pkg::cmd_t    cmd;
	tank_game_pkg::status_t status;

	logic                        xfer;
	logic                        fire_pend;	// fire_req as seen from outside
	logic [`TANK_NUM_ENEMY-1:0]  hit_mask;
	tank_geom_pkg::cell_t        exp_cell;
	tank_geom_pkg::dir_t         exp_dir;
	tank_geom_pkg::dir_t         bul_dir;	// launch heading of the model bullet
	int                          exp_state;
	logic [`TANK_SCORE_BITS-1:0] exp_score;
	int                          cycles = 0;

	tank_game_top i_tank_game_top (
		.clk		(clk),
		.rst_n		(rst_n),
		.start		(start),
		.cmd_valid	(cmd_valid),
		.cmd		(cmd),
		.cmd_ready	(cmd_ready),
		.status		(status)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// one cell in d and held at the border
	function automatic tank_geom_pkg::cell_t clamp_step(tank_geom_pkg::cell_t c,
			tank_geom_pkg::dir_t d);
		tank_geom_pkg::cell_t n;
		n = c;
		case (d)
			tank_geom_pkg::DIR_UP:    if (c.y != 0) n.y = c.y - 1'b1;
			tank_geom_pkg::DIR_DOWN:  if (c.y != `TANK_GRID_MAX) n.y = c.y + 1'b1;
			tank_geom_pkg::DIR_LEFT:  if (c.x != 0) n.x = c.x - 1'b1;
			tank_geom_pkg::DIR_RIGHT: if (c.x != `TANK_GRID_MAX) n.x = c.x + 1'b1;
		endcase
		return n;
	endfunction

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Checks failed");
		$fatal(1, "run stopped at first error");
	endtask

	assign xfer = cmd_valid && cmd_ready;

	always_comb begin
		for (int i = 0; i < `TANK_NUM_ENEMY; i++) begin
			hit_mask[i] = status.running && status.bul_active && status.alive[i]
				&& status.bul_cell == SPAWN[i];
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYC) begin
			fail_run("Timeout: the run did not finish within the cycle limit");
		end
	end

	// reference model
	always @(posedge clk) begin
		if (!rst_n) begin
			exp_cell  <= START_CELL;
			exp_dir   <= tank_geom_pkg::DIR_UP;
			bul_dir   <= tank_geom_pkg::DIR_UP;
			fire_pend <= 1'b0;
			exp_state <= ST_IDLE;
			exp_score <= '0;
		end else begin
			fire_pend <= xfer && cmd.fire;
			if (xfer && cmd.move) begin
				exp_cell <= clamp_step(exp_cell, cmd.dir);
				exp_dir  <= cmd.dir;
			end
			if (fire_pend && !status.bul_active) bul_dir <= exp_dir;
			if (exp_state != ST_RUN && start) begin
				exp_state <= ST_RUN;
				exp_score <= '0;
			end else if (exp_state == ST_RUN && |hit_mask) begin
				exp_score <= exp_score + 1'b1;
				if (exp_score + 1 == `TANK_SCORE_LIMIT) exp_state <= ST_OVER;
			end
		end
	end

	a_idle: assert property (@(posedge clk) disable iff (!rst_n) exp_state == ST_IDLE |->
		!cmd_ready && !status.running && !status.game_over && !status.bul_active
		&& status.score == 0 && status.alive == '1 && status.player_cell == START_CELL
		&& status.player_dir == tank_geom_pkg::DIR_UP)
		else fail_run($sformatf("Error status = %h while idle, cmd_ready = %h",
			$sampled(status), $sampled(cmd_ready)));
	a_cell: assert property (@(posedge clk) disable iff (!rst_n) status.player_cell == exp_cell)
		else fail_run($sformatf("Error status.player_cell = %h, expected %h",
			$sampled(status.player_cell), $sampled(exp_cell)));
	a_dir: assert property (@(posedge clk) disable iff (!rst_n) status.player_dir == exp_dir)
		else fail_run($sformatf("Error status.player_dir = %h, expected %h",
			$sampled(status.player_dir), $sampled(exp_dir)));
	a_state: assert property (@(posedge clk) disable iff (!rst_n)
		int'(status.state) == exp_state
		&& {status.running, status.game_over} == {exp_state == ST_RUN, exp_state == ST_OVER})
		else fail_run($sformatf("Error status.state = %h, running/game_over = %h, expected %h",
			$sampled(status.state), $sampled({status.running, status.game_over}),
			$sampled(exp_state)));
	a_score: assert property (@(posedge clk) disable iff (!rst_n) status.score == exp_score)
		else fail_run($sformatf("Error status.score = %h, expected %h",
			$sampled(status.score), $sampled(exp_score)));
	a_ready_xfer: assert property (@(posedge clk) disable iff (!rst_n) xfer |=> !cmd_ready)
		else fail_run("Error cmd_ready = 1 after a transfer, expected 0");
	a_ready_stop: assert property (@(posedge clk) disable iff (!rst_n)
		!status.running |-> !cmd_ready)
		else fail_run("Error cmd_ready = 1 while not running, expected 0");
	a_launch: assert property (@(posedge clk) disable iff (!rst_n)
		xfer && cmd.fire && !status.bul_active |=> ##1
		status.bul_active && status.bul_cell == $past(status.player_cell))
		else fail_run("bullet was not launched from the tank cell");
	a_flight: assert property (@(posedge clk) disable iff (!rst_n) status.bul_active |=>
		!status.bul_active || $stable(status.bul_cell) || (status.bul_cell != $past(status.bul_cell)
		&& status.bul_cell == clamp_step($past(status.bul_cell), $past(bul_dir))))
		else fail_run("bullet cell moved other than one cell in its heading");
	a_border: assert property (@(posedge clk) disable iff (!rst_n)
		status.bul_active && clamp_step(status.bul_cell, bul_dir) == status.bul_cell
		|-> ##[1:`TANK_BUL_DIV + 1] !status.bul_active)
		else fail_run("bullet did not retire at the grid edge");
	a_hit: assert property (@(posedge clk) disable iff (!rst_n) |hit_mask |=> !status.bul_active
		&& (status.alive & $past(hit_mask)) == '0
		&& status.score == $past(status.score) + 1'b1)
		else fail_run("hit did not remove the enemy, retire the bullet and add a point");

	for (genvar i = 0; i < `TANK_NUM_ENEMY; i++) begin : g_respawn
		a_respawn: assert property (@(posedge clk) disable iff (!rst_n)
			hit_mask[i] |-> ##[1:RESPAWN_CYC] status.alive[i])
			else fail_run("enemy did not return after its respawn delay");
	end

	task automatic send_cmd(input logic mv, input tank_geom_pkg::dir_t d, input logic fr);
		@(negedge clk);
		cmd_valid = 1'b1;
		cmd       = '{move: mv, dir: d, fire: fr};
		while (!cmd_ready && status.running) @(negedge clk);
		@(negedge clk);	// transfer edge has passed
		cmd_valid = 1'b0;
	endtask

	task automatic steer_to(input int x, input int y);
		while (status.running && int'(status.player_cell.y) != y) begin
			send_cmd(1'b1, (int'(status.player_cell.y) > y) ? tank_geom_pkg::DIR_UP
				: tank_geom_pkg::DIR_DOWN, 1'b0);
		end
		while (status.running && int'(status.player_cell.x) != x) begin
			send_cmd(1'b1, (int'(status.player_cell.x) > x) ? tank_geom_pkg::DIR_LEFT
				: tank_geom_pkg::DIR_RIGHT, 1'b0);
		end
	endtask

	task automatic fire_at(input tank_geom_pkg::dir_t d);
		while (status.bul_active) @(negedge clk);
		send_cmd(1'b1, d, 1'b1);
		repeat (2) @(negedge clk);
		while (status.bul_active) @(negedge clk);	// hit or edge
	endtask

	task automatic random_cmds(input int n);
		for (int k = 0; k < n && status.running; k++) begin
			send_cmd($urandom_range(0, 3) != 0, tank_geom_pkg::dir_t'($urandom_range(0, 3)),
				$urandom_range(0, 3) == 0);
		end
	endtask

	task automatic pulse_start();
		@(negedge clk);
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
	endtask

	initial begin
		rst_n     = 1'b0;
		start     = 1'b0;
		cmd_valid = 1'b0;
		cmd       = '0;
		void'($urandom(32'ha650c855));
		repeat (10) @(negedge clk);
		rst_n = 1'b1;
		repeat (2 * MOVE_DIV) @(negedge clk);
		pulse_start();
		random_cmds(30);
		// line up under each spawn column and fire up and down
		while (!status.game_over) begin
			steer_to(`TANK_SPAWN_X0, `TANK_START_Y);
			fire_at(tank_geom_pkg::DIR_UP);
			fire_at(tank_geom_pkg::DIR_DOWN);
			steer_to(`TANK_SPAWN_X1, `TANK_START_Y);
			fire_at(tank_geom_pkg::DIR_UP);
			fire_at(tank_geom_pkg::DIR_DOWN);
		end
		repeat (3 * MOVE_DIV) @(negedge clk);
		pulse_start();
		random_cmds(6);
		repeat (2 * MOVE_DIV) @(negedge clk);
		$display("All checks passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+include
rtl/tank_geom_pkg.sv
rtl/tank_game_pkg.sv
rtl/tick_gen.sv
rtl/player_tank.sv
rtl/bullet_engine.sv
rtl/enemy_field.sv
rtl/game_ctrl.sv
rtl/tank_game_top.sv
test/tank_game_tb.sv
